//--- cpu_top.f
rtl/cpu_pkg.sv
rtl/dec_if.sv
rtl/sync_ram.sv
rtl/inst_decode.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/seq_divider.sv
rtl/cpu_core.sv
rtl/cpu_top.sv
dv/cpu_top_assert.sv
dv/tb_cpu_top.sv

//--- dv/cpu_top_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core_assert (
	input logic                 clock,
	input logic                 clr_n,
	input cpu_pkg::core_state_e state,
	input logic                 halted,
	input logic                 go,
	input logic                 out_valid,
	input logic                 div_start,
	input logic                 imem_we,
	input logic                 dmem_we,
	input logic                 stk_we
);
	import cpu_pkg::*;

	out_quiet_in_halt: assert property (@(posedge clock) disable iff (!clr_n)
		$rose(out_valid) |-> !halted)
		else $error("out_valid rose while the core was halted");

	halt_holds: assert property (@(posedge clock) disable iff (!clr_n)
		halted && !go |=> halted)
		else $error("halted dropped without a go strobe");

	div_waits: assert property (@(posedge clock) disable iff (!clr_n)
		div_start |=> state == st_div)
		else $error("divider started but the core did not wait for it");

	// only the load port may write while halted
	no_write_in_halt: assert property (@(posedge clock) disable iff (!clr_n)
		halted |-> !dmem_we && !stk_we)
		else $error("data or stack memory written while halted");

	load_only_in_halt: assert property (@(posedge clock) disable iff (!clr_n)
		imem_we |-> state == st_halt)
		else $error("instruction memory written outside the halt state");

endmodule

bind cpu_core cpu_core_assert u_core_assert (
	.clock(clock),
	.clr_n(clr_n),
	.state(state),
	.halted(halted),
	.go(go),
	.out_valid(out_valid),
	.div_start(div_start),
	.imem_we(imem_we),
	.dmem_we(dmem_we),
	.stk_we(stk_we)
);

`default_nettype wire

//--- dv/tb_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top;
	import cpu_pkg::*;

	localparam int ADDR_W     = 10;
	localparam int WAIT_LIMIT = 50;   // cycles to leave halt
	localparam int RUN_LIMIT  = 5000; // cycles for one program run

	logic              clock;
	logic              clr_n;
	logic              load_we;
	logic [ADDR_W-1:0] load_addr;
	word_t             idata;
	logic              go;
	word_t             odata;
	logic              out_valid;
	logic              halted;

	word_t       prog [$];  // program being assembled
	word_t       exp_q [$]; // expected odata sequence
	word_t       outs [$];  // odata seen at out_valid
	logic [15:0] lfsr_q;
	int          fail_count;

	cpu_top #(.ADDR_W(ADDR_W)) UUT (
		.clock(clock), .clr_n(clr_n), .load_we(load_we), .load_addr(load_addr),
		.idata(idata), .go(go), .odata(odata), .out_valid(out_valid), .halted(halted)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic report_error(string msg);
		fail_count++;
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(string name, word_t exp, word_t act);
		if (act !== exp) begin
			report_error($sformatf("[FAIL] %s: expected %h, got %h", name, exp, act));
		end
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		if (act !== exp) begin
			report_error($sformatf("[FAIL] %s: expected %h, got %h", name, exp, act));
		end
	endtask

	// fibonacci lfsr with taps 16 14 13 11
	function automatic word_t rand_word();
		word_t w;
		logic  fb;
		w = '0;
		for (int i = 0; i < 16; i++) begin
			fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
			lfsr_q = {lfsr_q[14:0], fb};
			w      = {w[14:0], fb};
		end
		return w;
	endfunction

	function automatic word_t sign_extend(logic [7:0] b);
		return {{8{b[7]}}, b};
	endfunction

	function automatic word_t func_word(func_e fn, reg_idx_t src, reg_idx_t dst);
		word_t w;
		w        = '0;
		w[15:12] = op_func;
		w[11:9]  = src;
		w[8:6]   = dst;
		w[5:0]   = fn;
		return w;
	endfunction

	function automatic word_t imm_word(major_e m, logic [7:0] b);
		word_t w;
		w        = '0;
		w[15:12] = m;
		w[7:0]   = b;
		return w;
	endfunction

	function automatic word_t addr_word(major_e m, logic [9:0] a);
		word_t w;
		w        = '0;
		w[15:12] = m;
		w[9:0]   = a;
		return w;
	endfunction

	task automatic emit(word_t w);
		prog.push_back(w);
	endtask

	task automatic emit_out(reg_idx_t r, word_t expected);
		emit(func_word(fn_out, r, 3'd0));
		exp_q.push_back(expected);
	endtask

	// sdal, sdah, strr puts a full word in r
	task automatic emit_const(reg_idx_t r, word_t v);
		emit(imm_word(op_sdal, v[7:0]));
		emit(imm_word(op_sdah, v[15:8]));
		emit(func_word(fn_strr, r, 3'd0));
	endtask

	task automatic apply_reset();
		@(posedge clock);
		clr_n   <= 1'b0;
		load_we <= 1'b0;
		go      <= 1'b0;
		repeat (4) @(posedge clock);
		clr_n <= 1'b1;
		prog.delete();
		exp_q.delete();
	endtask

	task automatic load_program();
		check_flag("halted", 1'b1, halted);
		for (int i = 0; i < prog.size(); i++) begin
			@(posedge clock);
			load_we   <= 1'b1;
			load_addr <= ADDR_W'(i);
			idata     <= prog[i];
		end
		@(posedge clock);
		load_we <= 1'b0;
	endtask

	task automatic run_until_halt();
		int n;
		outs.delete();
		@(posedge clock);
		go <= 1'b1;
		@(posedge clock);
		go <= 1'b0;
		n = 0;
		while (halted === 1'b1 && n < WAIT_LIMIT) begin
			@(negedge clock);
			n++;
		end
		if (halted !== 1'b0) begin
			report_error("timeout: the core did not leave halt after go");
		end
		n = 0;
		while (halted !== 1'b1 && n < RUN_LIMIT) begin
			@(negedge clock); // outputs settled here
			if (out_valid === 1'b1) begin
				outs.push_back(odata);
			end
			n++;
		end
		if (halted !== 1'b1) begin
			report_error("timeout: the program never reached stp");
		end
	endtask

	task automatic check_outputs();
		if (outs.size() != exp_q.size()) begin
			report_error($sformatf("expected %0d words on odata but saw %0d",
				exp_q.size(), outs.size()));
		end
		for (int i = 0; i < exp_q.size(); i++) begin
			check_word($sformatf("odata[%0d]", i), exp_q[i], outs[i]);
		end
		exp_q.delete();
	endtask

	task automatic immediates_out();
		word_t v;
		apply_reset();
		check_flag("halted", 1'b1, halted);
		v = rand_word();
		emit_const(3'd1, v);
		emit_out(3'd1, v);
		emit_const(3'd2, 16'hABCD);
		emit_out(3'd2, 16'hABCD);
		emit(imm_word(op_sdal, 8'h85)); // negative byte
		emit(func_word(fn_strr, 3'd3, 3'd0));
		emit_out(3'd3, sign_extend(8'h85));
		emit(imm_word(op_sdal, 8'h7F));
		emit(func_word(fn_strr, 3'd4, 3'd0));
		emit_out(3'd4, sign_extend(8'h7F));
		emit(imm_word(op_sdal, 8'h80));
		emit(imm_word(op_sdah, 8'h12)); // low byte kept
		emit(func_word(fn_strr, 3'd5, 3'd0));
		emit_out(3'd5, 16'h1280);
		emit(func_word(fn_stp, 3'd0, 3'd0));
		load_program();
		run_until_halt();
		check_outputs();
		@(negedge clock); // stays halted without go
		check_flag("halted", 1'b1, halted);
	endtask

	task automatic register_arith();
		word_t       a;
		word_t       b;
		word_t       r;
		logic [31:0] prod;
		apply_reset();
		for (int k = 0; k < 3; k++) begin
			a    = rand_word();
			b    = rand_word();
			prod = 32'(a) * 32'(b);
			emit_const(3'd1, a);
			emit_const(3'd2, b);
			emit(func_word(fn_mov, 3'd1, 3'd3));
			emit_out(3'd3, a);
			r = a + b;
			emit(func_word(fn_add, 3'd2, 3'd3));
			emit_out(3'd3, r);
			r = a - b;
			emit(func_word(fn_mov, 3'd1, 3'd4));
			emit(func_word(fn_sub, 3'd2, 3'd4));
			emit_out(3'd4, r);
			emit(func_word(fn_ldar, 3'd2, 3'd0));
			emit(func_word(fn_strr, 3'd5, 3'd0));
			emit_out(3'd5, b);
			emit(func_word(fn_ldar, 3'd1, 3'd0));
			emit(func_word(fn_mult, 3'd2, 3'd0));
			emit(func_word(fn_strr, 3'd6, 3'd0));
			emit_out(3'd6, prod[15:0]);
			emit(func_word(fn_xtda, 3'd0, 3'd0)); // high half from x
			emit(func_word(fn_strr, 3'd7, 3'd0));
			emit_out(3'd7, prod[31:16]);
		end
		emit(func_word(fn_stp, 3'd0, 3'd0));
		load_program();
		run_until_halt();
		check_outputs();
	endtask

	task automatic divide_ops();
		word_t a;
		word_t b;
		apply_reset();
		for (int k = 0; k < 4; k++) begin
			a = rand_word();
			b = rand_word() >> (k * 5);
			if (k == 3) begin
				b = '0;
			end else if (b == '0) begin
				b = 16'd1;
			end
			emit_const(3'd1, a);
			emit_const(3'd2, b);
			emit(func_word(fn_ldar, 3'd1, 3'd0));
			emit(func_word(fn_divi, 3'd2, 3'd0));
			emit(func_word(fn_strr, 3'd3, 3'd0));
			emit_out(3'd3, (b == '0) ? 16'hFFFF : word_t'(a / b));
			emit(func_word(fn_xtda, 3'd0, 3'd0));
			emit(func_word(fn_strr, 3'd4, 3'd0));
			emit_out(3'd4, (b == '0) ? a : word_t'(a % b));
		end
		emit(func_word(fn_stp, 3'd0, 3'd0));
		load_program();
		run_until_halt();
		check_outputs();
	endtask

	// sdal a byte, then jn over one out
	task automatic emit_sign_branch(logic [7:0] imm);
		word_t da_v;
		da_v = sign_extend(imm);
		emit(imm_word(op_sdal, imm));
		emit(addr_word(op_jn, 10'(prog.size() + 2)));
		emit(func_word(fn_out, 3'd6, 3'd0));
		if (da_v[15] == 1'b0) begin
			exp_q.push_back(16'h0055); // fall through
		end
		emit_out(3'd4, 16'h00AA);
	endtask

	task automatic mem_and_branch();
		word_t v;
		int    loop_at;
		apply_reset();
		v = rand_word();
		emit_const(3'd1, v);
		emit(addr_word(op_str, 10'h2A5));
		emit_const(3'd1, ~v);
		emit(addr_word(op_str, 10'h15A));
		emit(imm_word(op_sdal, 8'h00));
		emit(addr_word(op_lda, 10'h2A5));
		emit(func_word(fn_strr, 3'd2, 3'd0));
		emit_out(3'd2, v);
		emit_const(3'd1, 16'd5);
		emit_const(3'd2, 16'd1);
		loop_at = prog.size();
		emit(func_word(fn_out, 3'd1, 3'd0));
		emit(func_word(fn_sub, 3'd2, 3'd1));
		emit(func_word(fn_ldar, 3'd1, 3'd0));
		emit(addr_word(op_jz, 10'(loop_at + 5)));
		emit(addr_word(op_jmp, 10'(loop_at)));
		for (int c = 5; c > 0; c--) begin
			exp_q.push_back(word_t'(c));
		end
		emit_const(3'd4, 16'h00AA);
		emit_const(3'd6, 16'h0055);
		emit_sign_branch(8'h80);
		emit_sign_branch(8'h05);
		emit_sign_branch(8'hFF);
		emit_sign_branch(8'h00);
		emit(func_word(fn_stp, 3'd0, 3'd0));
		load_program();
		run_until_halt();
		check_outputs();
	endtask

	task automatic stack_and_resume();
		word_t p;
		word_t s;
		int    call_at;
		int    sub_at;
		apply_reset();
		p = rand_word();
		s = rand_word();
		emit_const(3'd1, p);
		emit_const(3'd3, s);
		emit_const(3'd4, 16'h0C0D);
		emit_const(3'd5, 16'h0AFE);
		emit_const(3'd6, 16'h1111);
		emit_const(3'd7, 16'h2222);
		emit(func_word(fn_push, 3'd1, 3'd0));
		emit(func_word(fn_push, 3'd3, 3'd0));
		emit(func_word(fn_sub, 3'd1, 3'd1));
		emit(func_word(fn_sub, 3'd3, 3'd3));
		emit_out(3'd1, 16'h0000);
		emit_out(3'd3, 16'h0000);
		emit(func_word(fn_pop, 3'd3, 3'd0)); // last in, first out
		emit(func_word(fn_pop, 3'd1, 3'd0));
		emit_out(3'd1, p);
		emit_out(3'd3, s);
		call_at = prog.size();
		emit('0); // call target patched below
		exp_q.push_back(16'h0C0D);
		emit_out(3'd5, 16'h0AFE);
		emit(func_word(fn_stp, 3'd0, 3'd0));
		emit(func_word(fn_out, 3'd6, 3'd0));
		emit(func_word(fn_out, 3'd7, 3'd0));
		emit(func_word(fn_stp, 3'd0, 3'd0));
		sub_at = prog.size();
		emit(func_word(fn_out, 3'd4, 3'd0));
		emit(func_word(fn_ret, 3'd0, 3'd0));
		prog[call_at] = addr_word(op_call, 10'(sub_at));
		load_program();
		run_until_halt();
		check_outputs();
		@(negedge clock); // stays halted without go
		check_flag("halted", 1'b1, halted);
		exp_q.push_back(16'h1111); // after resume
		exp_q.push_back(16'h2222);
		run_until_halt();
		check_outputs();
	endtask

	initial begin
		clr_n      = 1'b0;
		load_we    = 1'b0;
		load_addr  = '0;
		idata      = '0;
		go         = 1'b0;
		lfsr_q     = 16'd77;
		fail_count = 0;
		immediates_out();
		register_arith();
		divide_ops();
		mem_and_branch();
		stack_and_resume();
		if (fail_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  cpu_pkg::alu_op_e op,
	input  cpu_pkg::word_t   a,
	input  cpu_pkg::word_t   b,
	input  logic [7:0]       imm8,
	output cpu_pkg::word_t   res_hi,
	output cpu_pkg::word_t   res_lo
);
	import cpu_pkg::*;

	logic [31:0] prod;

	assign prod = a * b; // full width product

	always_comb begin
		res_hi = '0; // only mult fills the high half
		res_lo = b;
		case (op)
			alu_add:  res_lo = a + b;
			alu_sub:  res_lo = a - b;
			alu_pass: res_lo = b;
			alu_mult: begin
				res_hi = prod[31:16];
				res_lo = prod[15:0];
			end
			alu_sdal: res_lo = {{8{imm8[7]}}, imm8}; // sign extended byte
			alu_sdah: res_lo = {imm8, a[7:0]};       // keep low byte of a
			default:  res_lo = b;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core #(
	parameter int ADDR_W = 10
) (
	input  logic              clock,
	input  logic              clr_n,
	input  logic              load_we,
	input  logic [ADDR_W-1:0] load_addr,
	input  cpu_pkg::word_t    idata,
	input  logic              go,
	output logic [ADDR_W-1:0] imem_addr,
	output cpu_pkg::word_t    imem_wdata,
	output logic              imem_we,
	input  cpu_pkg::word_t    imem_q,
	output logic [ADDR_W-1:0] dmem_addr,
	output cpu_pkg::word_t    dmem_wdata,
	output logic              dmem_we,
	input  cpu_pkg::word_t    dmem_q,
	output logic [ADDR_W-1:0] stk_addr,
	output cpu_pkg::word_t    stk_wdata,
	output logic              stk_we,
	input  cpu_pkg::word_t    stk_q,
	output cpu_pkg::word_t    inst,
	dec_if.core               dec,
	output cpu_pkg::reg_idx_t rf_ra,
	output cpu_pkg::reg_idx_t rf_rb,
	input  cpu_pkg::word_t    rf_rdata_a,
	input  cpu_pkg::word_t    rf_rdata_b,
	output logic              rf_we,
	output cpu_pkg::reg_idx_t rf_waddr,
	output cpu_pkg::word_t    rf_wdata,
	output cpu_pkg::word_t    alu_a,
	output cpu_pkg::word_t    alu_b,
	input  cpu_pkg::word_t    alu_res_hi,
	input  cpu_pkg::word_t    alu_res_lo,
	output logic              div_start,
	output cpu_pkg::word_t    div_dividend,
	output cpu_pkg::word_t    div_divisor,
	input  logic              div_done,
	input  cpu_pkg::word_t    div_quot,
	input  cpu_pkg::word_t    div_rem,
	output cpu_pkg::word_t    odata,
	output logic              out_valid,
	output logic              halted
);
	import cpu_pkg::*;

	core_state_e       state;
	logic [ADDR_W-1:0] pc;        // already points past the current instruction in exec
	logic [ADDR_W-1:0] sp;
	logic [ADDR_W-1:0] resume_pc;
	word_t             da;
	word_t             x;
	word_t             inst_r;
	logic              in_exec;
	logic              is_push;
	logic              is_call;

	assign in_exec = (state == st_exec);
	assign inst    = in_exec ? imem_q : inst_r; // live word in exec, held afterwards
	assign is_push = in_exec && dec.major == op_func && dec.func == fn_push;
	assign is_call = in_exec && dec.major == op_call;

	// load port owns the instruction memory while halted
	assign imem_addr  = halted ? load_addr : pc;
	assign imem_wdata = idata;
	assign imem_we    = halted && load_we;

	assign dmem_addr  = dec.addr;
	assign dmem_wdata = da;
	assign dmem_we    = in_exec && dec.major == op_str;

	assign stk_addr  = (is_push || is_call) ? sp + 1'b1 : sp; // pre-increment on write
	assign stk_wdata = is_call ? word_t'(pc) : rf_rdata_b;
	assign stk_we    = is_push || is_call;

	assign rf_ra = dec.dst;
	assign rf_rb = dec.src;
	assign alu_a = (dec.alu_op == alu_mult || dec.alu_op == alu_sdah) ? da : rf_rdata_a;
	assign alu_b = rf_rdata_b;

	assign div_start    = in_exec && dec.major == op_func && dec.func == fn_divi;
	assign div_dividend = da;
	assign div_divisor  = rf_rdata_b;

	always_comb begin
		rf_we    = 1'b0;
		rf_waddr = dec.dst;
		rf_wdata = alu_res_lo;
		if (in_exec && dec.major == op_func) begin
			case (dec.func)
				fn_add, fn_sub, fn_mov: rf_we = 1'b1;
				fn_strr: begin
					rf_we    = 1'b1;
					rf_waddr = dec.src;
					rf_wdata = da;
				end
				default: rf_we = 1'b0;
			endcase
		end else if (state == st_stack && dec.major == op_func && dec.func == fn_pop) begin
			rf_we    = 1'b1;
			rf_waddr = dec.src;
			rf_wdata = stk_q;
		end
	end

	always_ff @(posedge clock or negedge clr_n) begin
		if (!clr_n) begin
			state     <= st_halt;
			pc        <= '0;
			sp        <= '1; // empty stack
			resume_pc <= '0;
			da        <= '0;
			x         <= '0;
			inst_r    <= '0;
			odata     <= '0;
			out_valid <= 1'b0;
			halted    <= 1'b1;
		end else begin
			out_valid <= 1'b0;
			case (state)
				st_halt: begin
					if (go) begin
						state  <= st_fetch;
						pc     <= resume_pc;
						halted <= 1'b0;
					end
				end
				st_fetch: begin
					pc    <= pc + 1'b1;
					state <= st_exec;
				end
				st_exec: begin
					inst_r <= imem_q;
					state  <= st_fetch;
					case (dec.major)
						op_func: begin
							case (dec.func)
								fn_push: sp <= sp + 1'b1;
								fn_pop, fn_ret: begin
									sp    <= sp - 1'b1;
									state <= st_stack;
								end
								fn_ldar: da <= rf_rdata_b;
								fn_out: begin
									odata     <= rf_rdata_b;
									out_valid <= 1'b1;
								end
								fn_mult: begin
									x  <= alu_res_hi;
									da <= alu_res_lo;
								end
								fn_divi: state <= st_div;
								fn_xtda: da <= x;
								fn_stp: begin
									resume_pc <= pc;
									halted    <= 1'b1;
									state     <= st_halt;
								end
								default: state <= st_fetch;
							endcase
						end
						op_lda:           state <= st_mem;
						op_sdal, op_sdah: da <= alu_res_lo;
						op_jmp:           pc <= dec.addr;
						op_jz:            if (da == '0) pc <= dec.addr;
						op_jn:            if (da[15]) pc <= dec.addr;
						op_call: begin
							sp <= sp + 1'b1;
							pc <= dec.addr;
						end
						default:          state <= st_fetch;
					endcase
				end
				st_mem: begin
					da    <= dmem_q;
					state <= st_fetch;
				end
				st_stack: begin
					if (dec.func == fn_ret) begin
						pc <= ADDR_W'(stk_q); // return address
					end
					state <= st_fetch;
				end
				st_div: begin
					if (div_done) begin
						da    <= div_quot;
						x     <= div_rem;
						state <= st_fetch;
					end
				end
				default: state <= st_halt;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	typedef logic [15:0] word_t;    // data and instruction word
	typedef logic [2:0]  reg_idx_t; // r0..r7

	// major opcode, bits 15..12
	typedef enum logic [3:0] {
		op_func = 4'd0,  // function code in bits 5..0
		op_lda  = 4'd1,
		op_str  = 4'd2,
		op_sdal = 4'd9,
		op_sdah = 4'd10,
		op_jmp  = 4'd11,
		op_jz   = 4'd12,
		op_jn   = 4'd13,
		op_call = 4'd14
	} major_e;

	// function codes under major 0
	typedef enum logic [5:0] {
		fn_nop  = 6'd0,
		fn_push = 6'd1,
		fn_pop  = 6'd2,
		fn_ldar = 6'd3,
		fn_strr = 6'd4,
		fn_add  = 6'd5,
		fn_sub  = 6'd6,
		fn_out  = 6'd7,
		fn_mov  = 6'd8,
		fn_mult = 6'd9,
		fn_divi = 6'd10,
		fn_xtda = 6'd11,
		fn_ret  = 6'd62,
		fn_stp  = 6'd63
	} func_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_pass,
		alu_mult,
		alu_sdal,
		alu_sdah
	} alu_op_e;

	typedef enum logic [2:0] {
		st_halt,
		st_fetch,
		st_exec,
		st_mem,   // data memory read returns
		st_stack, // stack read returns
		st_div    // waiting on divider
	} core_state_e;

endpackage

`default_nettype wire

//--- rtl/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
	parameter int ADDR_W = 10
) (
	input  logic              clock,
	input  logic              clr_n,
	input  logic              load_we,
	input  logic [ADDR_W-1:0] load_addr,
	input  cpu_pkg::word_t    idata,
	input  logic              go,
	output cpu_pkg::word_t    odata,
	output logic              out_valid,
	output logic              halted
);
	import cpu_pkg::*;

	logic [ADDR_W-1:0] imem_addr, dmem_addr, stk_addr;
	word_t             imem_wdata, dmem_wdata, stk_wdata;
	logic              imem_we, dmem_we, stk_we;
	word_t             imem_q, dmem_q, stk_q;
	word_t             inst;
	reg_idx_t          rf_ra, rf_rb, rf_waddr;
	word_t             rf_rdata_a, rf_rdata_b, rf_wdata;
	logic              rf_we;
	word_t             alu_a, alu_b, alu_res_hi, alu_res_lo;
	logic              div_start, div_done;
	word_t             div_dividend, div_divisor, div_quot, div_rem;

	dec_if #(.ADDR_W(ADDR_W)) dec_bus ();

	cpu_core #(.ADDR_W(ADDR_W)) u_core (
		.clock, .clr_n, .load_we, .load_addr, .idata, .go,
		.imem_addr, .imem_wdata, .imem_we, .imem_q,
		.dmem_addr, .dmem_wdata, .dmem_we, .dmem_q,
		.stk_addr, .stk_wdata, .stk_we, .stk_q,
		.inst, .dec(dec_bus.core),
		.rf_ra, .rf_rb, .rf_rdata_a, .rf_rdata_b, .rf_we, .rf_waddr, .rf_wdata,
		.alu_a, .alu_b, .alu_res_hi, .alu_res_lo,
		.div_start, .div_dividend, .div_divisor, .div_done, .div_quot, .div_rem,
		.odata, .out_valid, .halted
	);

	sync_ram #(.WIDTH($bits(word_t)), .DEPTH_W(ADDR_W)) imem (
		.clock, .addr(imem_addr), .wdata(imem_wdata), .we(imem_we), .q(imem_q)
	);

	sync_ram #(.WIDTH($bits(word_t)), .DEPTH_W(ADDR_W)) dmem (
		.clock, .addr(dmem_addr), .wdata(dmem_wdata), .we(dmem_we), .q(dmem_q)
	);

	sync_ram #(.WIDTH($bits(word_t)), .DEPTH_W(ADDR_W)) stk (
		.clock, .addr(stk_addr), .wdata(stk_wdata), .we(stk_we), .q(stk_q)
	);

	inst_decode u_dec (.inst, .dec(dec_bus.decoder));

	reg_file u_rf (
		.clock, .clr_n, .ra(rf_ra), .rb(rf_rb), .rdata_a(rf_rdata_a), .rdata_b(rf_rdata_b),
		.we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
	);

	alu u_alu (
		.op(dec_bus.alu_op), .a(alu_a), .b(alu_b), .imm8(dec_bus.imm8),
		.res_hi(alu_res_hi), .res_lo(alu_res_lo)
	);

	seq_divider u_div (
		.clock, .clr_n, .start(div_start), .dividend(div_dividend), .divisor(div_divisor),
		.done(div_done), .quot(div_quot), .rem(div_rem)
	);

endmodule

`default_nettype wire

//--- rtl/dec_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dec_if #(
	parameter int ADDR_W = 10
) ();
	import cpu_pkg::*;

	major_e            major;
	func_e             func;   // fn_nop unless major is op_func
	reg_idx_t          src;
	reg_idx_t          dst;
	logic [ADDR_W-1:0] addr;   // memory and jump target
	logic [7:0]        imm8;
	alu_op_e           alu_op;

	modport decoder (
		output major, func, src, dst, addr, imm8, alu_op
	);

	modport core (
		input major, func, src, dst, addr, imm8, alu_op
	);

endinterface

`default_nettype wire

//--- rtl/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
	input  cpu_pkg::word_t inst,
	dec_if.decoder         dec
);
	import cpu_pkg::*;

	logic    major_ok;
	logic    func_ok;
	major_e  major_v;
	func_e   func_v;
	alu_op_e alu_v;

	assign major_ok = inst[15:12] inside {4'd0, 4'd1, 4'd2, [4'd9:4'd14]};
	assign func_ok  = inst[5:0] inside {[6'd0:6'd11], 6'd62, 6'd63};

	always_comb begin
		major_v = major_ok ? major_e'(inst[15:12]) : op_func; // unknown major acts as nop
		func_v  = fn_nop;
		if (inst[15:12] == 4'd0 && func_ok) begin
			func_v = func_e'(inst[5:0]);
		end

		alu_v = alu_pass; // mov and everything without an ALU result
		case (major_v)
			op_sdal: alu_v = alu_sdal;
			op_sdah: alu_v = alu_sdah;
			op_func: begin
				case (func_v)
					fn_add:  alu_v = alu_add;
					fn_sub:  alu_v = alu_sub;
					fn_mult: alu_v = alu_mult;
					default: alu_v = alu_pass;
				endcase
			end
			default: alu_v = alu_pass;
		endcase
	end

	assign dec.major  = major_v;
	assign dec.func   = func_v;
	assign dec.alu_op = alu_v;
	assign dec.src    = inst[11:9];
	assign dec.dst    = inst[8:6];
	assign dec.imm8   = inst[7:0];
	assign dec.addr   = $bits(dec.addr)'(inst[9:0]); // address field is bits 9..0

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic              clock,
	input  logic              clr_n,
	input  cpu_pkg::reg_idx_t ra,
	input  cpu_pkg::reg_idx_t rb,
	output cpu_pkg::word_t    rdata_a,
	output cpu_pkg::word_t    rdata_b,
	input  logic              we,
	input  cpu_pkg::reg_idx_t waddr,
	input  cpu_pkg::word_t    wdata
);
	import cpu_pkg::*;

	word_t regs [8];

	always_ff @(posedge clock or negedge clr_n) begin
		if (!clr_n) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// reads see the old value during a write
	assign rdata_a = regs[ra];
	assign rdata_b = regs[rb];

endmodule

`default_nettype wire

//--- rtl/seq_divider.sv
`timescale 1ns/1ps
`default_nettype none

module seq_divider (
	input  logic           clock,
	input  logic           clr_n,
	input  logic           start,
	input  cpu_pkg::word_t dividend,
	input  cpu_pkg::word_t divisor,
	output logic           done,
	output cpu_pkg::word_t quot,
	output cpu_pkg::word_t rem
);
	import cpu_pkg::*;

	logic        busy;
	logic        fire;
	logic [3:0]  cnt;      // quotient bits already produced
	word_t       rem_r;
	word_t       quot_r;   // dividend shifts out as quotient shifts in
	word_t       div_r;
	word_t       cur_rem;
	word_t       cur_quot;
	word_t       cur_div;
	logic [16:0] shifted;
	logic [17:0] diff;

	assign fire = start && !busy;

	// first step runs straight off the inputs in the start cycle
	assign cur_rem  = busy ? rem_r : '0;
	assign cur_quot = busy ? quot_r : dividend;
	assign cur_div  = busy ? div_r : divisor;
	assign shifted  = {cur_rem, cur_quot[15]};
	assign diff     = {1'b0, shifted} - {2'b00, cur_div};

	always_ff @(posedge clock or negedge clr_n) begin
		if (!clr_n) begin
			busy <= 1'b0;
			cnt  <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (fire) begin
				busy <= 1'b1;
				cnt  <= 4'd1;
			end else if (busy) begin
				cnt <= cnt + 4'd1;
				if (cnt == 4'd15) begin // sixteenth bit this cycle
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (fire || busy) begin
			if (fire) begin
				div_r <= divisor;
			end
			if (diff[17]) begin // restore
				rem_r  <= shifted[15:0];
				quot_r <= {cur_quot[14:0], 1'b0};
			end else begin
				rem_r  <= diff[15:0];
				quot_r <= {cur_quot[14:0], 1'b1};
			end
		end
	end

	assign quot = quot_r;
	assign rem  = rem_r;

endmodule

`default_nettype wire

//--- rtl/sync_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sync_ram #(
	parameter int WIDTH   = 16,
	parameter int DEPTH_W = 10
) (
	input  logic               clock,
	input  logic [DEPTH_W-1:0] addr,
	input  logic [WIDTH-1:0]   wdata,
	input  logic               we,
	output logic [WIDTH-1:0]   q
);

	logic [WIDTH-1:0] mem [2**DEPTH_W];

	// old contents come out on a write to the same address
	always_ff @(posedge clock) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		q <= mem[addr]; // one clock read latency
	end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
LOG=sim.log

rm -rf obj_dir "$LOG" build.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu_top \
	-f cpu_top.f -o tb_cpu_top > build.log 2>&1 ||
	{ cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/tb_cpu_top > "$LOG" 2>&1 || echo "Testbench failed" >> "$LOG"
cat "$LOG"

grep -q "Testbench failed" "$LOG" && { echo "result: FAIL"; exit 1; }
echo "result: PASS"
